// ==== lsp_pol.f ====
rtl/lsp_pol_pkg.sv
rtl/fixed_point_ops.sv
rtl/scratch_ram.sv
rtl/lsp_pol_regs.sv
rtl/get_lsp_pol.sv
rtl/lsp_pol_top.sv
test/lsp_pol_checker.sv
test/lsp_pol_tb.sv

// ==== rtl/fixed_point_ops.sv ====
`timescale 1ns/100ps
`default_nettype none

module fixed_point_ops (
	input wire [31:0] msu_acc,
	input wire [15:0] msu_a,
	input wire [15:0] msu_b,
	output logic [31:0] msu_result,
	input wire [31:0] add_a,
	input wire [31:0] add_b,
	output logic [31:0] add_result,
	input wire [31:0] sub_a,
	input wire [31:0] sub_b,
	output logic [31:0] sub_result,
	input wire [31:0] shl_in,
	output logic [31:0] shl_result,
	input wire [15:0] mpy_hi,
	input wire [15:0] mpy_lo,
	input wire [15:0] mpy_n,
	output logic [31:0] mpy_result,
	input wire [31:0] extract_in,
	output logic [15:0] extract_hi,
	output logic [15:0] extract_lo
);

	logic [31:0] extract_tmp;

	// Clamp a 33-bit sum to 32 bits
	function automatic logic [31:0] sat_32(input logic [32:0] x);
		if (x[32] != x[31]) begin
			return x[32] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		end
		return x[31:0];
	endfunction

	function automatic logic [31:0] l_add(input logic [31:0] a, input logic [31:0] b);
		return sat_32({a[31], a} + {b[31], b});
	endfunction

	function automatic logic [31:0] l_sub(input logic [31:0] a, input logic [31:0] b);
		return sat_32({a[31], a} - {b[31], b});
	endfunction

	// -32768 * -32768 is the only overflowing product
	function automatic logic [31:0] l_mult(input logic signed [15:0] a,
			input logic signed [15:0] b);
		logic signed [31:0] p;
		p = a * b;
		if (p == 32'sh4000_0000) begin
			return 32'h7FFF_FFFF;
		end
		return {p[30:0], 1'b0};
	endfunction

	function automatic logic [15:0] mult_16(input logic signed [15:0] a,
			input logic signed [15:0] b);
		logic signed [31:0] p;
		p = (a * b) >>> 15;
		if (p > 32'sd32767) begin
			return 16'h7FFF;
		end
		return p[15:0];
	endfunction

	function automatic logic [31:0] l_shl_1(input logic [31:0] x);
		if (x[31] != x[30]) begin
			return x[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		end
		return {x[30:0], 1'b0};
	endfunction

	assign msu_result = l_sub(msu_acc, l_mult(msu_a, msu_b));
	assign add_result = l_add(add_a, add_b);
	assign sub_result = l_sub(sub_a, sub_b);
	assign shl_result = l_shl_1(shl_in);

	// Mpy_32_16 as L_mac(L_mult(hi, n), mult(lo, n), 1)
	assign mpy_result = l_add(l_mult(mpy_hi, mpy_n), l_mult(mult_16(mpy_lo, mpy_n), 16'sd1));

	// L_Extract, lo taken from (x >> 1) - hi * 16384
	assign extract_hi = extract_in[31:16];
	assign extract_tmp = l_sub({extract_in[31], extract_in[31:1]},
		l_mult(extract_in[31:16], 16'sd16384));
	assign extract_lo = extract_tmp[15:0];

endmodule

`default_nettype wire

// ==== rtl/get_lsp_pol.sv ====
`timescale 1ns/100ps
`default_nettype none

module get_lsp_pol
	import lsp_pol_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire start,
	input wire f_opt,
	output logic done,
	output mem_port_t mem_port,
	input wire [data_width-1:0] ram_rdata
);

	typedef enum logic [3:0] {
		st_idle,
		st_f0,
		st_f1,
		st_copy_rd,
		st_copy_wr,
		st_ex_rd,
		st_ex,
		st_mpy,
		st_add_rd,
		st_upd,
		st_lsp_rd,
		st_f1_wr,
		st_done
	} state_t;

	state_t state;
	logic [2:0] i_idx;
	logic [2:0] j_idx;
	logic [2:0] f_ptr;
	logic [3:0] lsp_ptr;
	logic [15:0] hi;
	logic [15:0] lo;
	logic [31:0] temp1;
	logic [31:0] temp2;

	logic [2:0] f_prev1;
	logic [2:0] f_prev2;
	logic [addr_width-1:0] region_base;
	logic [addr_width-1:0] addr_cur;
	logic [addr_width-1:0] addr_m1;
	logic [addr_width-1:0] addr_m2;
	logic [addr_width-1:0] addr_lsp;

	logic [31:0] msu_result;
	logic [31:0] add_result;
	logic [31:0] sub_result;
	logic [31:0] shl_result;
	logic [31:0] mpy_result;
	logic [15:0] extract_hi;
	logic [15:0] extract_lo;

	fixed_point_ops fixed_point_ops_i (
		.msu_acc(temp2),
		.msu_a(ram_rdata[15:0]),
		.msu_b(lsp_scale),
		.msu_result(msu_result),
		.add_a(temp2),
		.add_b(ram_rdata),
		.add_result(add_result),
		.sub_a(add_result),
		.sub_b(temp1),
		.sub_result(sub_result),
		.shl_in(mpy_result),
		.shl_result(shl_result),
		.mpy_hi(hi),
		.mpy_lo(lo),
		.mpy_n(ram_rdata[15:0]),
		.mpy_result(mpy_result),
		.extract_in(ram_rdata),
		.extract_hi(extract_hi),
		.extract_lo(extract_lo)
	);

	////////////////////////////////////////
	// Addresses of f[j], f[j-1], f[j-2]
	////////////////////////////////////////

	assign f_prev1 = f_ptr - 3'd1;
	assign f_prev2 = f_ptr - 3'd2;
	assign region_base = f_opt ? f2_base : f1_base;
	assign addr_cur = region_base + addr_width'(f_ptr);
	assign addr_m1 = region_base + addr_width'(f_prev1);
	assign addr_m2 = region_base + addr_width'(f_prev2);
	assign addr_lsp = lsp_base + addr_width'(lsp_ptr);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			i_idx <= 3'd2;
			j_idx <= '0;
			f_ptr <= '0;
			lsp_ptr <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_f0;
						i_idx <= 3'd2;
						f_ptr <= '0;
						lsp_ptr <= '0;
					end
				end
				st_f0: begin
					f_ptr <= 3'd1;
					state <= st_f1;
				end
				st_f1: begin
					f_ptr <= 3'd2;
					lsp_ptr <= lsp_ptr + 4'd2;
					state <= st_copy_rd;
				end
				st_copy_rd: state <= st_copy_wr;
				st_copy_wr: begin
					j_idx <= i_idx;
					state <= st_ex_rd;
				end
				// Inner loop runs while j >= 2
				st_ex_rd: state <= (j_idx < 3'd2) ? st_lsp_rd : st_ex;
				st_ex: state <= st_mpy;
				st_mpy: state <= st_add_rd;
				st_add_rd: state <= st_upd;
				st_upd: begin
					f_ptr <= f_prev1;
					j_idx <= j_idx - 3'd1;
					state <= st_ex_rd;
				end
				st_lsp_rd: state <= st_f1_wr;
				st_f1_wr: begin
					f_ptr <= f_ptr + i_idx;
					lsp_ptr <= lsp_ptr + 4'd2;
					i_idx <= i_idx + 3'd1;
					state <= (i_idx == 3'd5) ? st_done : st_copy_rd;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			// Zero accumulator for f[1] = L_msu(0, lsp[0], 512)
			st_f0: temp2 <= '0;
			st_ex: begin
				hi <= extract_hi;
				lo <= extract_lo;
			end
			st_mpy: temp1 <= shl_result;
			st_add_rd, st_lsp_rd: temp2 <= ram_rdata;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// RAM port, one access per state
	////////////////////////////////////////

	always_comb begin
		mem_port = '0;
		case (state)
			st_f0: begin
				mem_port.write_addr = addr_cur;
				mem_port.write_data = f0_value;
				mem_port.write_en = 1'b1;
				mem_port.read_addr = addr_lsp;
			end
			st_f1, st_f1_wr: begin
				mem_port.write_addr = addr_cur;
				mem_port.write_data = msu_result;
				mem_port.write_en = 1'b1;
			end
			st_copy_rd, st_add_rd: mem_port.read_addr = addr_m2;
			st_copy_wr: begin
				mem_port.write_addr = addr_cur;
				mem_port.write_data = ram_rdata;
				mem_port.write_en = 1'b1;
			end
			// f[1] itself once the inner loop is over
			st_ex_rd: mem_port.read_addr = (j_idx < 3'd2) ? addr_cur : addr_m1;
			st_ex, st_lsp_rd: mem_port.read_addr = addr_lsp;
			st_mpy: mem_port.read_addr = addr_cur;
			st_upd: begin
				mem_port.write_addr = addr_cur;
				mem_port.write_data = sub_result;
				mem_port.write_en = 1'b1;
			end
			default: ;
		endcase
	end

	assign done = state == st_done;

	a_f_ptr_range: assert property (@(posedge clock) disable iff (reset)
		mem_port.write_en |-> f_ptr <= 3'd5);

	// A start in the middle of a run would be lost
	a_start_while_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> state == st_idle);

endmodule

`default_nettype wire

// ==== rtl/lsp_pol_pkg.sv ====
`default_nettype none

package lsp_pol_pkg;

	////////////////////////////////////////
	// Scratch RAM geometry
	////////////////////////////////////////

	localparam int addr_width = 6;
	localparam int data_width = 32;
	localparam int host_addr_width = 7;

	// Word addresses inside the RAM
	localparam logic [addr_width-1:0] lsp_base = 6'd0;
	localparam logic [addr_width-1:0] f1_base = 6'd32;
	localparam logic [addr_width-1:0] f2_base = 6'd48;

	// Bit 6 of the host address selects control space
	localparam logic [host_addr_width-1:0] ctrl_addr = 7'd64;

	////////////////////////////////////////
	// Recurrence constants
	////////////////////////////////////////

	localparam logic [data_width-1:0] f0_value = 32'h0100_0000;
	localparam logic [15:0] lsp_scale = 16'd512;

	typedef struct packed {
		logic [addr_width-1:0] read_addr;
		logic [addr_width-1:0] write_addr;
		logic [data_width-1:0] write_data;
		logic write_en;
	} mem_port_t;

endpackage

`default_nettype wire

// ==== rtl/lsp_pol_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsp_pol_regs
	import lsp_pol_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire host_write,
	input wire host_read,
	input wire [host_addr_width-1:0] host_addr,
	input wire [data_width-1:0] host_wdata,
	output logic [data_width-1:0] host_rdata,
	output logic host_rvalid,
	output logic start,
	output logic f_opt,
	input wire done,
	input wire mem_port_t seq_port,
	input wire [data_width-1:0] ram_rdata,
	output mem_port_t ram_port
);

	logic busy;
	logic done_flag;
	logic ctrl_sel;
	logic ram_sel;
	logic start_accept;
	logic rd_ctrl;
	logic [1:0] rd_status;
	mem_port_t host_port;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign ctrl_sel = host_addr == ctrl_addr;
	assign ram_sel = !host_addr[host_addr_width-1];
	assign start_accept = host_write && ctrl_sel && host_wdata[0] && !busy;

	always_comb begin
		host_port.read_addr = host_addr[addr_width-1:0];
		host_port.write_addr = host_addr[addr_width-1:0];
		host_port.write_data = host_wdata;
		host_port.write_en = host_write && ram_sel && !busy;
	end

	// Sequencer owns the RAM for the whole run
	assign ram_port = busy ? seq_port : host_port;

	////////////////////////////////////////
	// Control and status
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done_flag <= 1'b0;
			start <= 1'b0;
			f_opt <= 1'b0;
			host_rvalid <= 1'b0;
			rd_ctrl <= 1'b0;
		end else begin
			start <= start_accept;
			host_rvalid <= host_read;
			if (host_read) begin
				rd_ctrl <= ctrl_sel;
			end
			if (start_accept) begin
				busy <= 1'b1;
				done_flag <= 1'b0;
				f_opt <= host_wdata[1];
			end else if (done) begin
				busy <= 1'b0;
				done_flag <= 1'b1;
			end
		end
	end

	// Status sampled at the read strobe
	always_ff @(posedge clock) begin
		if (host_read) begin
			rd_status <= {done_flag, busy};
		end
	end

	assign host_rdata = rd_ctrl ? {{(data_width-2){1'b0}}, rd_status} : ram_rdata;

	// Sequencer finishes only a run that was handed the RAM
	a_done_while_busy: assert property (@(posedge clock) disable iff (reset)
		done |-> busy);

endmodule

`default_nettype wire

// ==== rtl/lsp_pol_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsp_pol_top
	import lsp_pol_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire host_write,
	input wire host_read,
	input wire [host_addr_width-1:0] host_addr,
	input wire [data_width-1:0] host_wdata,
	output logic [data_width-1:0] host_rdata,
	output logic host_rvalid,
	output logic pol_done
);

	logic start;
	logic f_opt;
	mem_port_t seq_port;
	mem_port_t ram_port;
	logic [data_width-1:0] ram_rdata;

	lsp_pol_regs lsp_pol_regs_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.host_read(host_read),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.host_rvalid(host_rvalid),
		.start(start),
		.f_opt(f_opt),
		.done(pol_done),
		.seq_port(seq_port),
		.ram_rdata(ram_rdata),
		.ram_port(ram_port)
	);

	// Done pulse goes straight out as pol_done
	get_lsp_pol get_lsp_pol_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.f_opt(f_opt),
		.done(pol_done),
		.mem_port(seq_port),
		.ram_rdata(ram_rdata)
	);

	scratch_ram scratch_ram_i (
		.clock(clock),
		.mem_port(ram_port),
		.rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// ==== rtl/scratch_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module scratch_ram
	import lsp_pol_pkg::*;
(
	input wire clock,
	input wire mem_port_t mem_port,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [0:(2**addr_width)-1];

	// Read sees the old word on a same-address write
	always_ff @(posedge clock) begin
		if (mem_port.write_en) begin
			mem[mem_port.write_addr] <= mem_port.write_data;
		end
		rdata <= mem[mem_port.read_addr];
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lsp_pol testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module lsp_pol_tb \
	-f lsp_pol.f --Mdir obj_dir -o lsp_pol_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/lsp_pol_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== test/lsp_pol_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsp_pol_checker
	import lsp_pol_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire host_write,
	input wire host_read,
	input wire [host_addr_width-1:0] host_addr,
	input wire [data_width-1:0] host_wdata,
	input wire [data_width-1:0] host_rdata,
	input wire host_rvalid,
	input wire pol_done,
	output int error_count,
	output int check_count
);

	// Shadow of the RAM as the host should see it
	logic [data_width-1:0] shadow [0:(2**addr_width)-1];
	logic model_busy;
	logic model_done;
	logic run_f_opt;
	logic read_pending;
	logic [host_addr_width-1:0] read_addr;
	logic [data_width-1:0] read_expect;

	////////////////////////////////////////
	// Saturating arithmetic model
	////////////////////////////////////////

	function automatic int sat32(input longint x);
		if (x > 64'sd2147483647) begin
			return 32'sh7FFF_FFFF;
		end
		if (x < -64'sd2147483648) begin
			return 32'sh8000_0000;
		end
		return int'(x);
	endfunction

	function automatic int l_add(input int a, input int b);
		return sat32(longint'(a) + longint'(b));
	endfunction

	function automatic int l_sub(input int a, input int b);
		return sat32(longint'(a) - longint'(b));
	endfunction

	function automatic int l_mult(input shortint a, input shortint b);
		if (a == 16'sh8000 && b == 16'sh8000) begin
			return 32'sh7FFF_FFFF;
		end
		return sat32(longint'(a) * longint'(b) * 64'sd2);
	endfunction

	function automatic shortint mult_q15(input shortint a, input shortint b);
		longint p;
		p = (longint'(a) * longint'(b)) >>> 15;
		if (p > 64'sd32767) begin
			return 16'sh7FFF;
		end
		return shortint'(p);
	endfunction

	function automatic int l_msu(input int acc, input shortint a, input shortint b);
		return l_sub(acc, l_mult(a, b));
	endfunction

	function automatic int l_shl1(input int x);
		return sat32(longint'(x) * 64'sd2);
	endfunction

	function automatic int mpy_32_16(input shortint hi, input shortint lo, input shortint n);
		return l_add(l_mult(hi, n), l_mult(mult_q15(lo, n), 16'sd1));
	endfunction

	function automatic void split_word(input int x, output shortint hi, output shortint lo);
		int t;
		hi = shortint'(x >>> 16);
		t = l_sub(x >>> 1, l_mult(hi, 16'sd16384));
		lo = shortint'(t);
	endfunction

	// Get_lsp_pol recurrence into the selected region
	function automatic void compute_poly();
		int f [0:5];
		int t0;
		int i;
		int j;
		int k;
		shortint n;
		shortint hi;
		shortint lo;
		logic [addr_width-1:0] base;
		f[0] = f0_value;
		f[1] = l_msu(0, shortint'(shadow[lsp_base]), lsp_scale);
		for (i = 2; i <= 5; i++) begin
			n = shortint'(shadow[lsp_base + addr_width'(2 * i - 2)]);
			f[i] = f[i - 2];
			for (j = i; j >= 2; j--) begin
				split_word(f[j - 1], hi, lo);
				t0 = l_shl1(mpy_32_16(hi, lo, n));
				f[j] = l_sub(l_add(f[j], f[j - 2]), t0);
			end
			f[1] = l_msu(f[1], n, lsp_scale);
		end
		base = run_f_opt ? f2_base : f1_base;
		for (k = 0; k < 6; k++) begin
			shadow[base + addr_width'(k)] = f[k];
		end
	endfunction

	////////////////////////////////////////
	// Host port monitor
	////////////////////////////////////////

	always @(negedge clock) begin
		if (reset) begin
			model_busy = 1'b0;
			model_done = 1'b0;
			run_f_opt = 1'b0;
			read_pending = 1'b0;
			error_count = 0;
			check_count = 0;
		end else begin
			// Response to the read strobe of one cycle ago
			if (host_rvalid !== read_pending) begin
				$display("FAILED host_rvalid: expected %h, got %h", read_pending, host_rvalid);
				error_count++;
			end else if (read_pending) begin
				check_count++;
				if (host_rdata !== read_expect) begin
					$display("FAILED host_rdata at address %h: expected %h, got %h",
						read_addr, read_expect, host_rdata);
					error_count++;
				end
			end
			read_pending = host_read;
			if (host_read) begin
				read_addr = host_addr;
				if (host_addr == ctrl_addr) begin
					read_expect = {30'd0, model_done, model_busy};
				end else begin
					read_expect = shadow[host_addr[addr_width-1:0]];
				end
			end
			// Writes and starts only count while idle
			if (host_write && !model_busy) begin
				if (host_addr == ctrl_addr && host_wdata[0]) begin
					model_busy = 1'b1;
					model_done = 1'b0;
					run_f_opt = host_wdata[1];
				end else if (!host_addr[host_addr_width-1]) begin
					shadow[host_addr[addr_width-1:0]] = host_wdata;
				end
			end
			if (pol_done) begin
				if (!model_busy) begin
					$display("pol_done pulsed while no run was in progress");
					error_count++;
				end else begin
					compute_poly();
					model_busy = 1'b0;
					model_done = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/lsp_pol_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsp_pol_tb
	import lsp_pol_pkg::*;
();

	localparam int num_runs = 6;
	localparam int run_cycles = 200;
	localparam int clock_period = 40;
	localparam int done_timeout = 200;

	logic clock;
	logic reset;
	logic host_write;
	logic host_read;
	logic [host_addr_width-1:0] host_addr;
	logic [data_width-1:0] host_wdata;
	logic [data_width-1:0] host_rdata;
	logic host_rvalid;
	logic pol_done;
	int error_count;
	int check_count;
	integer seed;
	int test_num;
	int tb_errors;
	int errors_before;

	lsp_pol_top lsp_pol_top_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.host_read(host_read),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.host_rvalid(host_rvalid),
		.pol_done(pol_done)
	);

	lsp_pol_checker lsp_pol_checker_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.host_read(host_read),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.host_rvalid(host_rvalid),
		.pol_done(pol_done),
		.error_count(error_count),
		.check_count(check_count)
	);

	always #(clock_period / 2) clock = ~clock;

	// Watchdog
	initial begin
		#(num_runs * run_cycles * clock_period);
		$display("Timeout after %0d ns, the run never finished", num_runs * run_cycles * clock_period);
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////////////////////////
	// Host access
	////////////////////////////////////////

	task automatic write_word(input logic [host_addr_width-1:0] addr, input logic [31:0] data);
		host_write <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
		@(posedge clock);
		host_write <= 1'b0;
	endtask

	task automatic read_word(input logic [host_addr_width-1:0] addr);
		host_read <= 1'b1;
		host_addr <= addr;
		@(posedge clock);
		host_read <= 1'b0;
	endtask

	task automatic start_run(input logic f_opt);
		write_word(ctrl_addr, {30'd0, f_opt, 1'b1});
	endtask

	task automatic wait_for_done();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < done_timeout) begin
			@(negedge clock);
			seen = pol_done;
			cycles++;
		end
		@(posedge clock);
		if (!seen) begin
			$display("pol_done did not arrive within %0d cycles", done_timeout);
			tb_errors++;
		end
	endtask

	task automatic load_random_lsps();
		int k;
		for (k = 0; k < 10; k++) begin
			write_word(host_addr_width'(k), $random(seed));
		end
	endtask

	// Mode 0 alternates the extremes, mode 1 cycles through them and zero
	task automatic load_extreme_lsps(input int mode);
		int k;
		logic [15:0] v;
		for (k = 0; k < 10; k++) begin
			if (mode == 0) begin
				v = k[0] ? 16'h7FFF : 16'h8000;
			end else begin
				case (k % 3)
					0: v = 16'h8000;
					1: v = 16'h7FFF;
					default: v = 16'h0000;
				endcase
			end
			write_word(host_addr_width'(k), {{16{v[15]}}, v});
		end
	endtask

	task automatic read_region(input logic [addr_width-1:0] base);
		int k;
		for (k = 0; k < 6; k++) begin
			read_word({1'b0, base + addr_width'(k)});
		end
	endtask

	task automatic read_lsps();
		int k;
		for (k = 0; k < 10; k++) begin
			read_word(host_addr_width'(k));
		end
	endtask

	task automatic finish_test(input string name);
		int errors;
		repeat (3) @(posedge clock);
		errors = error_count + tb_errors - errors_before;
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(errors == 0) ? "pass" : "fail", errors);
		errors_before = error_count + tb_errors;
		test_num++;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int total;
		clock = 1'b0;
		reset = 1'b1;
		host_write = 1'b0;
		host_read = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		seed = 32;
		test_num = 1;
		tb_errors = 0;
		errors_before = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		read_word(ctrl_addr);
		repeat (10) @(posedge clock);
		finish_test("idle after reset");

		load_random_lsps();
		start_run(1'b0);
		wait_for_done();
		read_region(f1_base);
		read_word(ctrl_addr);
		finish_test("random lsps into F1");

		load_random_lsps();
		start_run(1'b1);
		wait_for_done();
		read_region(f2_base);
		read_region(f1_base);
		read_word(ctrl_addr);
		finish_test("random lsps into F2");

		load_extreme_lsps(0);
		start_run(1'b0);
		wait_for_done();
		read_region(f1_base);
		load_extreme_lsps(1);
		start_run(1'b1);
		wait_for_done();
		read_region(f2_base);
		finish_test("extreme lsps");

		// Second start and an LSP write land while busy
		load_random_lsps();
		start_run(1'b0);
		write_word(ctrl_addr, 32'h0000_0003);
		write_word(7'd3, 32'hDEAD_BEEF);
		wait_for_done();
		repeat (70) @(posedge clock);
		read_lsps();
		read_region(f1_base);
		read_word(ctrl_addr);
		finish_test("writes ignored while busy");

		start_run(1'b0);
		read_word(ctrl_addr);
		wait_for_done();
		read_word(ctrl_addr);
		read_region(f1_base);
		finish_test("start clears sticky done");

		total = error_count + tb_errors;
		$display("%0d tests, %0d reads checked, %0d errors", test_num - 1, check_count, total);
		if (total == 0 && check_count > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
